/* verilog/t08_macros.svh */
`ifndef T08_MACROS_SVH
`define T08_MACROS_SVH

// Datapath and register file geometry
`define T08_XLEN   32
`define T08_NREGS  32
`define T08_REG_AW 5

// Major opcodes handled by the slice
`define T08_OP_RTYPE 7'b0110011 // ADD, SUB, AND, ...
`define T08_OP_ITYPE 7'b0010011 // ADDI, ANDI, SLLI, ...
`define T08_OP_LUI   7'b0110111
`define T08_OP_LOAD  7'b0000011 // Only LW is legal

// Cycles spent in MEM_WAIT before the load is aborted
`define T08_MEM_TIMEOUT 16

`endif

/* verilog/t08_pkg.sv */
`include "t08_macros.svh"

package t08_pkg;

    // R-type layout and the U-type immediate fields of LUI
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`T08_REG_AW-1:0] rs2;
        logic [`T08_REG_AW-1:0] rs1;
        logic [2:0]             funct3;
        logic [`T08_REG_AW-1:0] rd;
        logic [6:0]             opcode;
    } r_fmt_t;

    // I-type layout for immediates and LW
    typedef struct packed {
        logic [11:0]            imm12;
        logic [`T08_REG_AW-1:0] rs1;
        logic [2:0]             funct3;
        logic [`T08_REG_AW-1:0] rd;
        logic [6:0]             opcode;
    } i_fmt_t;

    // One instruction word seen either way
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    // Encoding is {funct7[5], funct3} so decode is a plain cast
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_op_e;

    // Writeback source select
    typedef enum logic [1:0] {
        WB_NONE = 2'b00,
        WB_MEM  = 2'b01,
        WB_IMM  = 2'b10,
        WB_ALU  = 2'b11
    } wb_sel_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_DECODE,
        S_EXECUTE,
        S_MEM_WAIT,
        S_WRITEBACK
    } state_e;

endpackage

/* verilog/t08_rf_if.sv */
`include "t08_macros.svh"

interface t08_rf_if;

    logic [`T08_REG_AW-1:0] rs1_addr;  // Read port 1 address
    logic [`T08_REG_AW-1:0] rs2_addr;  // Read port 2 address
    logic                   rd1_en;    // Port 1 follows its address while high
    logic                   rd2_en;
    logic [`T08_REG_AW-1:0] rd_addr;   // Write address
    logic                   wr_en;
    logic [`T08_XLEN-1:0]   wr_data;
    logic [`T08_XLEN-1:0]   rs1_data;  // Holds last value when rd1_en is low
    logic [`T08_XLEN-1:0]   rs2_data;

    // Control side
    modport ctrl (
        output rs1_addr, rs2_addr, rd1_en, rd2_en, rd_addr, wr_en, wr_data,
        input  rs1_data, rs2_data
    );

    // Register file side
    modport regs (
        input  rs1_addr, rs2_addr, rd1_en, rd2_en, rd_addr, wr_en, wr_data,
        output rs1_data, rs2_data
    );

endinterface

/* verilog/t08_registers.sv */
`include "t08_macros.svh"

module t08_registers (
    input logic clk,
    input logic reset,
    input logic busy,      // Blocks the write while high
    t08_rf_if.regs rf
);

    logic [`T08_NREGS-1:0][`T08_XLEN-1:0] regs;

    // Last value driven on each read port
    logic [`T08_XLEN-1:0] rd1_q;
    logic [`T08_XLEN-1:0] rd2_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            regs  <= '0;
            rd1_q <= '0;
            rd2_q <= '0;
        end else begin
            rd1_q <= rf.rs1_data;
            rd2_q <= rf.rs2_data;

            // x0 is never written
            if (rf.wr_en && !busy && rf.rd_addr != '0) begin
                regs[rf.rd_addr] <= rf.wr_data;
            end
        end
    end

    // Read port 1
    always_comb begin
        rf.rs1_data = rd1_q;                   // Hold when not enabled
        if (rf.rd1_en) begin
            if (rf.rs1_addr == '0) begin
                rf.rs1_data = '0;              // x0 reads zero
            end else begin
                rf.rs1_data = regs[rf.rs1_addr];
            end
        end
    end

    // Read port 2, same rules
    always_comb begin
        rf.rs2_data = rd2_q;
        if (rf.rd2_en) begin
            if (rf.rs2_addr == '0) begin
                rf.rs2_data = '0;
            end else begin
                rf.rs2_data = regs[rf.rs2_addr];
            end
        end
    end

endmodule

/* verilog/t08_alu.sv */
`include "t08_macros.svh"

module t08_alu import t08_pkg::*; (
    input  alu_op_e              op,
    input  logic [`T08_XLEN-1:0] a,
    input  logic [`T08_XLEN-1:0] b,
    output logic [`T08_XLEN-1:0] y
);

    logic [4:0] shamt;  // Shift amount, low bits of b only

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD: begin
                y = a + b;
            end
            ALU_SUB: begin
                y = a - b;
            end
            ALU_SLL: begin
                y = a << shamt;
            end
            ALU_SLT: begin
                // Signed compare
                y = {{(`T08_XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            end
            ALU_SLTU: begin
                y = {{(`T08_XLEN-1){1'b0}}, (a < b)};  // Unsigned compare
            end
            ALU_XOR: begin
                y = a ^ b;
            end
            ALU_SRL: begin
                y = a >> shamt;              // Zero fill
            end
            ALU_SRA: begin
                y = $signed(a) >>> shamt;    // Sign fill
            end
            ALU_OR: begin
                y = a | b;
            end
            ALU_AND: begin
                y = a & b;
            end
            default: begin
                y = '0;                      // Unused encodings
            end
        endcase
    end

endmodule

/* verilog/t08_control.sv */
`include "t08_macros.svh"

module t08_control import t08_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   busy,
    input  logic                   instr_valid,
    input  instr_u                 instr,
    output logic                   ready,
    t08_rf_if.ctrl                 rf,
    output alu_op_e                alu_op,
    output logic [`T08_XLEN-1:0]   alu_a,
    output logic [`T08_XLEN-1:0]   alu_b,
    input  logic [`T08_XLEN-1:0]   alu_y,
    output logic                   mem_req,
    output logic [`T08_XLEN-1:0]   mem_addr,
    input  logic                   mem_ready,
    input  logic [`T08_XLEN-1:0]   mem_rdata,
    output logic                   timer_start,
    input  logic                   timer_expired,
    output logic                   wb_valid,
    output logic [`T08_REG_AW-1:0] wb_rd,
    output logic [`T08_XLEN-1:0]   wb_data,
    output logic                   illegal,
    output logic                   bus_error
);

    state_e state, state_n;
    instr_u instr_q;                       // Word under execution
    logic [`T08_XLEN-1:0] op_a, op_b;      // Operands latched in DECODE
    logic [`T08_XLEN-1:0] alu_res;         // Latched in EXECUTE
    logic [`T08_XLEN-1:0] mem_data;        // Load data from MEM_WAIT
    logic [`T08_XLEN-1:0] imm;
    wb_sel_e wb_sel;
    logic legal, is_r;

    // Decode reads the held word as R-type and as I-type
    always_comb begin
        legal  = 1'b0;
        is_r   = 1'b0;
        alu_op = ALU_ADD;
        wb_sel = WB_NONE;
        imm    = {{(`T08_XLEN-12){instr_q.i.imm12[11]}}, instr_q.i.imm12};
        case (instr_q.r.opcode)
            `T08_OP_RTYPE: begin
                is_r   = 1'b1;
                wb_sel = WB_ALU;
                if (instr_q.r.funct7 == 7'b0000000) begin
                    legal  = 1'b1;
                    alu_op = alu_op_e'({1'b0, instr_q.r.funct3});
                end else if (instr_q.r.funct7 == 7'b0100000 &&
                             (instr_q.r.funct3 == 3'b000 || instr_q.r.funct3 == 3'b101)) begin
                    legal  = 1'b1;                        // SUB or SRA
                    alu_op = alu_op_e'({1'b1, instr_q.r.funct3});
                end
            end
            `T08_OP_ITYPE: begin
                wb_sel = WB_ALU;
                alu_op = alu_op_e'({1'b0, instr_q.i.funct3});
                case (instr_q.i.funct3)
                    3'b001: legal = (instr_q.r.funct7 == 7'b0000000);  // SLLI
                    3'b101: begin
                        // Upper imm bits act as funct7 for SRLI and SRAI
                        legal = (instr_q.r.funct7 == 7'b0000000) ||
                                (instr_q.r.funct7 == 7'b0100000);
                        if (instr_q.r.funct7[5]) begin
                            alu_op = ALU_SRA;
                        end
                    end
                    default: legal = 1'b1;
                endcase
            end
            `T08_OP_LUI: begin
                legal  = 1'b1;
                wb_sel = WB_IMM;
                imm    = {instr_q.r.funct7, instr_q.r.rs2, instr_q.r.rs1,
                          instr_q.r.funct3, 12'b0};        // U-type immediate
            end
            `T08_OP_LOAD: begin
                legal  = (instr_q.i.funct3 == 3'b010);     // LW only
                wb_sel = WB_MEM;                           // Address via ADD
            end
            default: legal = 1'b0;
        endcase
    end

    always_comb begin
        state_n = state;
        case (state)
            S_IDLE:      if (instr_valid) state_n = S_DECODE;
            S_DECODE:    state_n = legal ? S_EXECUTE : S_IDLE;
            S_EXECUTE:   state_n = (wb_sel == WB_MEM) ? S_MEM_WAIT : S_WRITEBACK;
            S_MEM_WAIT: begin
                if (mem_ready) begin
                    state_n = S_WRITEBACK;
                end else if (timer_expired) begin
                    state_n = S_IDLE;                      // Abort the load
                end
            end
            S_WRITEBACK: if (!busy) state_n = S_IDLE;
            default:     state_n = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= S_IDLE;
            instr_q <= '0;
            op_a    <= '0;
            op_b    <= '0;
        end else begin
            state <= state_n;
            if (state == S_IDLE && instr_valid) instr_q <= instr;
            if (state == S_DECODE) begin
                op_a <= rf.rs1_data;
                op_b <= is_r ? rf.rs2_data : imm;          // Immediate for I, LUI, LW
            end
        end
    end

    // ALU result and load data held for WRITEBACK
    always_ff @(posedge clk) begin
        if (state == S_EXECUTE) alu_res <= alu_y;
        if (state == S_MEM_WAIT && mem_ready) mem_data <= mem_rdata;  // First ready cycle
    end

    assign ready = (state == S_IDLE);

    // Register file port
    assign rf.rs1_addr = instr_q.r.rs1;
    assign rf.rs2_addr = instr_q.r.rs2;
    assign rf.rd1_en   = (state == S_DECODE);
    assign rf.rd2_en   = (state == S_DECODE) && is_r;  // Only R-type has rs2
    assign rf.rd_addr  = instr_q.r.rd;
    assign rf.wr_en    = (state == S_WRITEBACK);
    assign rf.wr_data  = wb_data;

    assign alu_a = op_a;
    assign alu_b = op_b;

    assign mem_req     = (state == S_EXECUTE) && (wb_sel == WB_MEM);
    assign mem_addr    = alu_y;                         // rs1 + sext(imm)
    assign timer_start = (state == S_MEM_WAIT);

    // Writeback data select
    always_comb begin
        wb_data = '0;
        if (state == S_WRITEBACK && instr_q.r.rd != '0) begin  // x0 traces as zero
            case (wb_sel)
                WB_ALU:  wb_data = alu_res;
                WB_MEM:  wb_data = mem_data;
                WB_IMM:  wb_data = op_b;
                default: wb_data = '0;
            endcase
        end
    end

    assign wb_valid  = (state == S_WRITEBACK) && !busy;
    assign wb_rd     = instr_q.r.rd;
    assign illegal   = (state == S_DECODE) && !legal;
    assign bus_error = (state == S_MEM_WAIT) && !mem_ready && timer_expired;

endmodule

/* verilog/t08_mem_timer.sv */
`include "t08_macros.svh"

module t08_mem_timer (
    input  logic clk,
    input  logic reset,
    input  logic start,     // Level, high while the load waits
    output logic expired    // Registered, high once the limit is hit
);

    localparam int CW = $clog2(`T08_MEM_TIMEOUT + 1);

    logic [CW-1:0] count;

    always_ff @(posedge clk) begin
        if (reset || !start) begin
            count   <= '0;    // Clear between waits
            expired <= 1'b0;
        end else begin
            if (count != CW'(`T08_MEM_TIMEOUT)) begin
                count <= count + 1'b1;  // Saturates at the limit
            end
            // Goes high on the same edge count reaches the limit
            expired <= (count >= CW'(`T08_MEM_TIMEOUT - 1));
        end
    end

endmodule

/* verilog/t08_core.sv */
`include "t08_macros.svh"

module t08_core import t08_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instr_valid,  // Fetch offers a word
    input  logic [`T08_XLEN-1:0]   instr,
    output logic                   ready,        // High only in IDLE
    output logic                   mem_req,      // One cycle per load
    output logic [`T08_XLEN-1:0]   mem_addr,
    input  logic                   mem_ready,
    input  logic [`T08_XLEN-1:0]   mem_rdata,
    input  logic                   busy,         // Back-pressure on writeback
    output logic                   wb_valid,
    output logic [`T08_REG_AW-1:0] wb_rd,
    output logic [`T08_XLEN-1:0]   wb_data,
    output logic                   illegal,
    output logic                   bus_error
);

    t08_rf_if rf_bus ();

    alu_op_e              alu_op;
    logic [`T08_XLEN-1:0] alu_a;
    logic [`T08_XLEN-1:0] alu_b;
    logic [`T08_XLEN-1:0] alu_y;
    logic                 timer_start;
    logic                 timer_expired;

    t08_control i_control (
        .clk           (clk),
        .reset         (reset),
        .busy          (busy),
        .instr_valid   (instr_valid),
        .instr         (instr),        // Seen as a union inside
        .ready         (ready),
        .rf            (rf_bus.ctrl),
        .alu_op        (alu_op),
        .alu_a         (alu_a),
        .alu_b         (alu_b),
        .alu_y         (alu_y),
        .mem_req       (mem_req),
        .mem_addr      (mem_addr),
        .mem_ready     (mem_ready),
        .mem_rdata     (mem_rdata),
        .timer_start   (timer_start),
        .timer_expired (timer_expired),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .illegal       (illegal),
        .bus_error     (bus_error)
    );

    // Same busy gates the actual write
    t08_registers i_registers (
        .clk   (clk),
        .reset (reset),
        .busy  (busy),
        .rf    (rf_bus.regs)
    );

    t08_alu i_alu (
        .op (alu_op),
        .a  (alu_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    t08_mem_timer i_mem_timer (
        .clk     (clk),
        .reset   (reset),
        .start   (timer_start),
        .expired (timer_expired)
    );

endmodule

/* sim/t08_core_assertions.sv */
module t08_core_assertions (
    input logic clk,
    input logic reset,
    input logic busy,
    input logic ready,
    input logic mem_req,
    input logic wb_valid,
    input logic illegal,
    input logic bus_error
);
    timeunit 1ns;
    timeprecision 1ps;

    // One request per load
    req_single: assert property (@(posedge clk) disable iff (reset) mem_req |=> !mem_req)
        else $error("mem_req held for more than one cycle");

    wb_not_busy: assert property (@(posedge clk) disable iff (reset) !(wb_valid && busy))
        else $error("wb_valid while busy is high");

    // IDLE never traces a write
    ready_wb: assert property (@(posedge clk) disable iff (reset) !(ready && wb_valid))
        else $error("ready and wb_valid high together");

    ill_berr: assert property (@(posedge clk) disable iff (reset) !(illegal && bus_error))
        else $error("illegal and bus_error in the same cycle");

endmodule

bind t08_core t08_core_assertions i_assertions (.*);

/* sim/t08_core_tb.sv */
`include "t08_macros.svh"

module t08_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic clk = 0, reset, instr_valid, mem_ready, busy;
    logic [31:0] instr, mem_rdata, mem_addr, wb_data;
    logic ready, mem_req, wb_valid, illegal, bus_error;
    logic [4:0] wb_rd;

    logic [31:0] model [32];                   // Expected register contents
    int errors = 0, checks = 0, tests = 0;
    logic s_wb, s_ill, s_berr;                 // What ended the last instruction
    logic [4:0] s_rd;
    logic [31:0] s_data, s_addr;
    int s_lat;                                 // Cycles from acceptance to the end

    t08_core i_t08_core (.*);

    always #20 clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `T08_OP_RTYPE};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    // RV32I integer result where alt selects SUB and SRA
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Offer one word and follow it until wb_valid, illegal or bus_error
    task automatic exec(input logic [31:0] w, input int busy_n, input int mem_n,
                        input logic [31:0] mem_val);
        int guard = 0;
        int req_at = -1;
        @(negedge clk);                        // Sample ready away from the edge
        while (!ready) begin
            if (++guard > 50) begin
                $display("Timed out waiting for ready");
                errors++;
                return;
            end
            @(negedge clk);
        end
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= w;
        @(posedge clk);                        // Accepted here
        instr_valid <= 1'b0;
        if (busy_n > 0) busy <= 1'b1;
        s_lat = 0;
        forever begin
            @(negedge clk);
            s_lat++;
            if (mem_req) begin
                req_at = s_lat;
                s_addr = mem_addr;
            end
            if (wb_valid || illegal || bus_error) break;
            if (s_lat > 60) begin
                $display("Timed out waiting for the instruction to finish");
                errors++;
                break;
            end
            @(posedge clk);
            if (s_lat >= busy_n) busy <= 1'b0;
            if (req_at >= 0 && mem_n >= 0 && s_lat >= req_at + mem_n) begin
                mem_ready <= 1'b1;             // Memory answers after mem_n cycles
                mem_rdata <= mem_val;
            end
        end
        {s_wb, s_ill, s_berr, s_rd, s_data} = {wb_valid, illegal, bus_error, wb_rd, wb_data};
        @(posedge clk);                        // Write lands here
        mem_ready <= 1'b0;
        busy      <= 1'b0;
    endtask

    task automatic do_alu(input logic [31:0] w, input logic [4:0] rd, input logic [31:0] exp,
                          input int busy_n);
        exec(w, busy_n, -1, 0);
        check_val("wb_valid", s_wb, 1);
        check_val("wb_rd", s_rd, rd);
        check_val("wb_data", s_data, rd == 0 ? 0 : exp);
        check_val("latency", s_lat, busy_n >= 3 ? busy_n + 1 : 3);
        if (rd != 0) model[rd] = exp;
    endtask

    task automatic rand_alu(input int busy_n);
        logic r = $urandom % 2;
        logic alt = $urandom % 2;
        logic [2:0] f3 = $urandom;
        logic [4:0] rd = 1 + $urandom % 31, rs1 = $urandom, rs2 = $urandom;
        logic [11:0] imm = $urandom;
        logic [31:0] b;
        if (f3 != 0 && f3 != 5) alt = 0;
        if (!r && f3 == 0) alt = 0;            // No SUBI
        if (!r && (f3 == 1 || f3 == 5)) imm = {1'b0, alt, 5'b0, imm[4:0]};
        b = r ? model[rs2] : {{20{imm[11]}}, imm};
        do_alu(r ? enc_r({1'b0, alt, 5'b0}, rs2, rs1, f3, rd)
                 : enc_i(imm, rs1, f3, rd, `T08_OP_ITYPE),
               rd, alu_ref(f3, alt, model[rs1], b), busy_n);
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        $display("Test %s finished with %0d errors", name, errors - err_before);
    endtask

    initial begin
        int e;
        logic [4:0] rd, rs1;
        logic [11:0] imm;
        logic [19:0] u;
        logic [31:0] val;
        void'($urandom(5));
        {instr_valid, mem_ready, busy, instr, mem_rdata} = '0;
        reset = 1'b1;
        foreach (model[i]) model[i] = 0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        e = errors;                            // Reset state and ADDI 0 sweep
        @(negedge clk);
        check_val("ready", ready, 1);
        check_val("outputs", {wb_valid, mem_req, illegal, bus_error}, 0);
        for (int r = 0; r < 32; r++) do_alu(enc_i(0, r, 0, r, `T08_OP_ITYPE), r, 0, 0);
        end_test("reset", e);

        e = errors;
        repeat (40) rand_alu(0);
        end_test("alu", e);

        e = errors;                            // LUI, x0 writes and x0 reads
        rd = 1 + $urandom % 31;
        u = $urandom;
        do_alu({u, rd, `T08_OP_LUI}, rd, {u, 12'b0}, 0);
        do_alu({u, 5'd0, `T08_OP_LUI}, 0, 0, 0);
        do_alu(enc_i(0, 0, 0, 5, `T08_OP_ITYPE), 5, 0, 0);
        do_alu(enc_r(0, rd, 0, 0, 6), 6, model[rd], 0);
        end_test("lui_x0", e);

        e = errors;
        repeat (8) rand_alu(4 + $urandom % 7);
        end_test("busy", e);

        e = errors;                            // Loads with and without an answer
        repeat (6) begin
            rd = 1 + $urandom % 31;
            rs1 = $urandom;
            imm = $urandom;
            val = $urandom;
            exec(enc_i(imm, rs1, 3'b010, rd, `T08_OP_LOAD), 0, $urandom % 8, val);
            check_val("mem_addr", s_addr, model[rs1] + {{20{imm[11]}}, imm});
            check_val("wb_valid", s_wb, 1);
            check_val("wb_rd", s_rd, rd);
            check_val("wb_data", s_data, val);
            model[rd] = val;
        end
        rd = rd % 31 + 1;                      // Not the register the last load wrote
        exec(enc_i(imm, rs1, 3'b010, rd, `T08_OP_LOAD), 0, -1, 0);
        check_val("bus_error", s_berr, 1);
        check_val("wb_valid", s_wb, 0);
        do_alu(enc_i(0, rd, 0, rd, `T08_OP_ITYPE), rd, model[rd], 0);
        end_test("load", e);

        e = errors;
        exec({25'h1abcdef, 7'b1111111}, 0, -1, 0);
        check_val("illegal", s_ill, 1);
        check_val("wb_valid", s_wb, 0);
        @(negedge clk);
        check_val("ready", ready, 1);
        end_test("illegal", e);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Last resort if a wait ever stalls
    initial begin
        #2ms;
        $display("Simulation stalled past its time limit");
        $display("Something failed");
        $finish;
    end

endmodule

/* files.f */
+incdir+verilog
verilog/t08_pkg.sv
verilog/t08_rf_if.sv
verilog/t08_registers.sv
verilog/t08_alu.sv
verilog/t08_control.sv
verilog/t08_mem_timer.sv
verilog/t08_core.sv
sim/t08_core_assertions.sv
sim/t08_core_tb.sv
